//--- sources.f
+incdir+.
lsu_pkg.sv
access_align.sv
load_extract.sv
lsu_apb_master.sv
apb_data_mem.sv
lsu_top.sv
tb_lsu.sv

//--- Bender.yml
package:
  name: lsu

sources:
  - files:
      - lsu_pkg.sv
      - access_align.sv
      - load_extract.sv
      - lsu_apb_master.sv
      - apb_data_mem.sv
      - lsu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_lsu.sv

//--- tb_lsu_model.svh
`ifndef TB_LSU_MODEL_SVH
`define TB_LSU_MODEL_SVH

// byte-wide image of the data memory, little endian
logic [7:0] model_mem [mem_words*8];

function automatic int access_bytes(logic [2:0] f3);
    return 1 << f3[1:0];
endfunction

// refused before any bus transfer
function automatic logic is_refused(logic write, logic [2:0] f3, logic [31:0] addr);
    logic bad_code;
    logic misaligned;
    case (f3)
        f3_b, f3_h, f3_w, f3_d: bad_code = 1'b0;
        f3_bu, f3_hu, f3_wu:    bad_code = write;  // loads only
        default:                bad_code = 1'b1;
    endcase
    misaligned = (addr % 32'(access_bytes(f3))) != 32'd0;
    return bad_code | misaligned;
endfunction

function automatic logic out_of_range(logic [31:0] addr);
    return addr >= 32'(mem_words * 8);
endfunction

function automatic logic [63:0] load_value(logic [2:0] f3, logic [31:0] addr);
    int n;
    logic [63:0] v;
    n = access_bytes(f3);
    v = '0;
    for (int i = 0; i < n; i++) begin
        v[8*i +: 8] = model_mem[addr + i];
    end
    if (!f3[2] && n < 8 && v[8*n-1]) begin
        v = v | (~64'd0 << (8 * n));  // sign extension
    end
    return v;
endfunction

function automatic void store_bytes(logic [2:0] f3, logic [31:0] addr, logic [63:0] wdata);
    for (int i = 0; i < access_bytes(f3); i++) begin
        model_mem[addr + i] = wdata[8*i +: 8];
    end
endfunction

function automatic logic [63:0] fill_pattern(int idx);
    return {32'(idx) * 32'h9e37_79b1, ~(32'(idx) ^ 32'hc3a5_0f96)};
endfunction

`endif

//--- tb_lsu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_lsu import lsu_pkg::*; ();

    localparam int addr_width     = 32;
    localparam int mem_words      = 256;
    localparam int wait_states    = 2;
    localparam int reset_cycles   = 10;
    localparam int total_requests = 836;  // fill, store_load, lanes, refused, range, mix
    localparam int cycle_limit    = total_requests * (5 + wait_states) + reset_cycles + 200;

    logic                  clk;
    logic                  rst_n;
    logic                  req_valid;
    logic                  req_write;
    logic [2:0]            req_funct3;
    logic [addr_width-1:0] req_addr;
    logic [xlen-1:0]       req_wdata;
    logic                  req_ready;
    logic                  resp_valid;
    logic                  resp_err;
    logic [xlen-1:0]       resp_rdata;

    int    check_count;
    int    err_count;
    int    test_errs;
    int    timing_errs;
    int    cycle_count = 0;
    string cur_test;

    `include "tb_lsu_model.svh"

    lsu_top #(
        .addr_width  (addr_width),
        .mem_words   (mem_words),
        .wait_states (wait_states)
    ) DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_funct3 (req_funct3),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_err   (resp_err),
        .resp_rdata (resp_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout waiting for response");
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            test_errs++;
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) $display("test %s: ok", cur_test);
        else $display("test %s: %0d errors", cur_test, test_errs);
    endtask

    // one request, from acceptance to response pulse
    task automatic issue_request(input logic write, input logic [2:0] f3,
                                 input logic [31:0] addr, input logic [63:0] wdata,
                                 input int exp_lat, output logic err,
                                 output logic [63:0] rdata);
        int   lat;
        logic ready_hi;
        int   errs_before;
        req_valid  <= 1'b1;
        req_write  <= write;
        req_funct3 <= f3;
        req_addr   <= addr;
        req_wdata  <= wdata;
        do @(posedge clk); while (!req_ready);
        req_valid <= 1'b0;
        lat      = 0;
        ready_hi = 1'b0;
        do begin
            @(posedge clk);
            lat++;
            if (req_ready) ready_hi = 1'b1;
        end while (!resp_valid);
        err   = resp_err;
        rdata = resp_rdata;
        errs_before = err_count;
        check($sformatf("%s latency", cur_test), 64'(exp_lat), 64'(lat));
        check($sformatf("%s ready low", cur_test), 64'd0, 64'(ready_hi));
        timing_errs += err_count - errs_before;
    endtask

    task automatic run_access(input string what, input logic write, input logic [2:0] f3,
                              input logic [31:0] addr, input logic [63:0] wdata);
        logic        refused;
        logic        exp_err;
        logic [63:0] exp_data;
        logic        err;
        logic [63:0] rdata;
        string       name;
        refused  = is_refused(write, f3, addr);
        exp_err  = refused | out_of_range(addr);
        exp_data = '0;
        if (!exp_err && !write) exp_data = load_value(f3, addr);
        name = $sformatf("%s %s f3=%0d addr=%h", cur_test, what, f3, addr);
        issue_request(write, f3, addr, wdata, refused ? 1 : 3 + wait_states, err, rdata);
        check({name, " err"}, 64'(exp_err), 64'(err));
        if (!exp_err && !write) check({name, " data"}, exp_data, rdata);
        if (!exp_err && write) store_bytes(f3, addr, wdata);
    endtask

    function automatic logic [31:0] rand_addr(int size);
        return $urandom_range(mem_words * 8 - 1) & ~(32'(size) - 32'd1);
    endfunction

    function automatic logic [63:0] rand_data();
        return {$urandom, $urandom};
    endfunction

    initial begin
        logic [2:0]  f3;
        logic [2:0]  lf;
        logic [31:0] a;
        logic        wr;
        req_valid   = 1'b0;
        req_write   = 1'b0;
        req_funct3  = '0;
        req_addr    = '0;
        req_wdata   = '0;
        rst_n       = 1'b0;
        check_count = 0;
        err_count   = 0;
        timing_errs = 0;
        void'($urandom(32'he94e502c));
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        begin_test("fill");  // whole memory gets a known image first
        for (int i = 0; i < mem_words; i++) run_access("sd", 1'b1, f3_d, i * 8, fill_pattern(i));
        end_test();

        begin_test("store_load");
        for (int i = 0; i < 24; i++) begin
            f3 = 3'(i % 4);
            a  = rand_addr(access_bytes(f3));
            run_access("store", 1'b1, f3, a, rand_data());
            for (int k = 0; k < 7; k++) begin
                lf = 3'(k);
                run_access("load", 1'b0, lf, a & ~(32'(access_bytes(lf)) - 32'd1), '0);
            end
        end
        end_test();

        begin_test("lane_isolation");
        for (int i = 0; i < 16; i++) begin
            f3 = (i % 2) ? f3_h : f3_b;
            a  = rand_addr(access_bytes(f3));
            run_access("store", 1'b1, f3, a, rand_data());
            run_access("ld", 1'b0, f3_d, a & ~32'h7, '0);
        end
        end_test();

        begin_test("refused");
        for (int i = 0; i < 16; i++) begin
            if (i % 3 == 2) begin
                wr = 1'($urandom % 2);
                f3 = wr ? 3'(4 + $urandom % 4) : 3'b111;
                a  = rand_addr(8);
            end else begin
                wr = 1'(i % 3);
                f3 = 3'(1 + $urandom % 3);
                a  = rand_addr(8) | 32'd1 | ($urandom & 32'h6);  // odd offset
            end
            run_access("bad", wr, f3, a, rand_data());
            run_access("ld", 1'b0, f3_d, a & ~32'h7, '0);
        end
        end_test();

        begin_test("out_of_range");
        for (int i = 0; i < 8; i++) begin
            a = 32'(mem_words * 8) + ($urandom_range(255) << 3);
            run_access("sd", 1'b1, f3_d, a, rand_data());
            run_access("ld", 1'b0, f3_d, a, '0);
            run_access("alias ld", 1'b0, f3_d, a - 32'(mem_words * 8), '0);
        end
        end_test();

        begin_test("random_mix");
        for (int i = 0; i < 300; i++) begin
            wr = 1'($urandom % 2);
            f3 = 3'($urandom);
            a  = $urandom_range(mem_words * 8 + 255);
            if ($urandom % 4 != 0) a = a & ~(32'(access_bytes(f3)) - 32'd1);
            run_access(wr ? "store" : "load", wr, f3, a, rand_data());
        end
        end_test();

        if (timing_errs == 0) $display("test timing: ok");
        else $display("test timing: %0d errors", timing_errs);

        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- lsu_top.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_top import lsu_pkg::*; #(
    parameter int addr_width  = 32,
    parameter int mem_words   = 256,
    parameter int wait_states = 1
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  req_valid,
    input  wire logic                  req_write,
    input  wire logic [2:0]            req_funct3,
    input  wire logic [addr_width-1:0] req_addr,
    input  wire logic [xlen-1:0]       req_wdata,
    output logic                       req_ready,
    output logic                       resp_valid,
    output logic                       resp_err,
    output logic      [xlen-1:0]       resp_rdata
);

    logic [2:0]            funct3_q;
    logic [2:0]            offset_q;
    logic                  write_q;
    logic [xlen-1:0]       wdata_q;
    logic [strb_width-1:0] strb;
    logic [xlen-1:0]       lane_wdata;
    logic                  bad;
    logic [xlen-1:0]       ext_rdata;

    logic [addr_width-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [xlen-1:0]       pwdata;
    logic [strb_width-1:0] pstrb;
    logic [xlen-1:0]       prdata;
    logic                  pready;
    logic                  pslverr;

    lsu_apb_master #(
        .addr_width (addr_width)
    ) u_master (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_funct3 (req_funct3),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_ready  (req_ready),
        .funct3_q   (funct3_q),
        .offset_q   (offset_q),
        .write_q    (write_q),
        .wdata_q    (wdata_q),
        .strb       (strb),
        .lane_wdata (lane_wdata),
        .bad        (bad),
        .ext_rdata  (ext_rdata),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .pstrb      (pstrb),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .resp_valid (resp_valid),
        .resp_err   (resp_err),
        .resp_rdata (resp_rdata)
    );

    access_align u_align (
        .funct3     (funct3_q),
        .write      (write_q),
        .offset     (offset_q),
        .wdata      (wdata_q),
        .strb       (strb),
        .lane_wdata (lane_wdata),
        .bad        (bad)
    );

    load_extract u_extract (
        .funct3    (funct3_q),
        .offset    (offset_q),
        .rdata     (prdata),
        .ext_rdata (ext_rdata)
    );

    apb_data_mem #(
        .addr_width  (addr_width),
        .mem_words   (mem_words),
        .wait_states (wait_states)
    ) u_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

endmodule

`default_nettype wire

//--- apb_data_mem.sv
`timescale 1ns/10ps
`default_nettype none

module apb_data_mem import lsu_pkg::*; #(
    parameter int addr_width  = 32,
    parameter int mem_words   = 256,
    parameter int wait_states = 1
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic [addr_width-1:0] paddr,
    input  wire logic                  psel,
    input  wire logic                  penable,
    input  wire logic                  pwrite,
    input  wire logic [xlen-1:0]       pwdata,
    input  wire logic [strb_width-1:0] pstrb,
    output logic      [xlen-1:0]       prdata,
    output logic                       pready,
    output logic                       pslverr
);

    localparam int idx_w = $clog2(mem_words);

    logic [xlen-1:0]  mem [mem_words];
    logic [2:0]       wait_cnt;        // covers 0 to 7 wait states
    logic [idx_w-1:0] idx;
    logic             in_range;
    logic             access;

    assign idx      = paddr[idx_w+2:3];
    assign in_range = (paddr >> (idx_w + 3)) == '0;
    assign access   = psel & penable;

    assign pready  = access & (wait_cnt == 3'(wait_states));
    assign pslverr = pready & ~in_range;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (pready) begin
            wait_cnt <= '0;
        end else if (access) begin
            wait_cnt <= wait_cnt + 3'd1;
        end
    end

    // read in the setup cycle, held through the wait states
    always_ff @(posedge clk) begin
        if (psel && !penable) begin
            prdata <= in_range ? mem[idx] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (pready && pwrite && in_range) begin
            for (int i = 0; i < strb_width; i++) begin
                if (pstrb[i]) begin
                    mem[idx][8*i +: 8] <= pwdata[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- lsu_apb_master.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_apb_master import lsu_pkg::*; #(
    parameter int addr_width = 32
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,

    input  wire logic                  req_valid,
    input  wire logic                  req_write,
    input  wire logic [2:0]            req_funct3,
    input  wire logic [addr_width-1:0] req_addr,
    input  wire logic [xlen-1:0]       req_wdata,
    output logic                       req_ready,

    output logic      [2:0]            funct3_q,
    output logic      [2:0]            offset_q,
    output logic                       write_q,
    output logic      [xlen-1:0]       wdata_q,
    input  wire logic [strb_width-1:0] strb,
    input  wire logic [xlen-1:0]       lane_wdata,
    input  wire logic                  bad,
    input  wire logic [xlen-1:0]       ext_rdata,

    output logic      [addr_width-1:0] paddr,
    output logic                       psel,
    output logic                       penable,
    output logic                       pwrite,
    output logic      [xlen-1:0]       pwdata,
    output logic      [strb_width-1:0] pstrb,
    input  wire logic [xlen-1:0]       prdata,
    input  wire logic                  pready,
    input  wire logic                  pslverr,

    output logic                       resp_valid,
    output logic                       resp_err,
    output logic      [xlen-1:0]       resp_rdata
);

    localparam logic [1:0] st_idle   = 2'd0;
    localparam logic [1:0] st_setup  = 2'd1;
    localparam logic [1:0] st_access = 2'd2;
    localparam logic [1:0] st_resp   = 2'd3;

    logic [1:0]            state;
    logic [addr_width-1:0] addr_q;
    logic                  err_q;
    logic                  accept;
    logic                  refuse;
    logic                  done;

    assign accept = req_valid & req_ready;
    assign refuse = (state == st_setup) & bad;  // answered without a transfer
    assign done   = (state == st_access) & pready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:   if (accept) state <= st_setup;
                st_setup:  state <= bad ? st_idle : st_access;
                st_access: if (pready) state <= st_resp;
                default:   state <= st_idle;
            endcase
        end
    end

    // request held for the whole transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            funct3_q <= req_funct3;
            addr_q   <= req_addr;
            write_q  <= req_write;
            wdata_q  <= req_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            resp_rdata <= ext_rdata;  // prdata is only valid with pready
            err_q      <= pslverr;
        end
    end

    assign offset_q  = addr_q[2:0];
    assign req_ready = (state == st_idle);

    assign paddr   = {addr_q[addr_width-1:3], 3'b000};  // doubleword aligned
    assign psel    = ((state == st_setup) & ~bad) | (state == st_access);
    assign penable = (state == st_access);
    assign pwrite  = write_q;
    assign pwdata  = lane_wdata;
    assign pstrb   = write_q ? strb : '0;

    assign resp_valid = (state == st_resp) | refuse;
    assign resp_err   = ((state == st_resp) & err_q) | refuse;

endmodule

`default_nettype wire

//--- load_extract.sv
`timescale 1ns/10ps
`default_nettype none

module load_extract import lsu_pkg::*; (
    input  wire logic [2:0]      funct3,
    input  wire logic [2:0]      offset,
    input  wire lane_word_t      rdata,
    output logic      [xlen-1:0] ext_rdata
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic [31:0] word_sel;

    // lane picked by the low address bits
    assign byte_sel = rdata.b[offset];
    assign half_sel = rdata.h[offset[2:1]];
    assign word_sel = rdata.w[offset[2]];

    always_comb begin
        case (funct3)
            f3_b: begin
                ext_rdata = {{(xlen-8){byte_sel[7]}}, byte_sel};
            end
            f3_h: begin
                ext_rdata = {{(xlen-16){half_sel[15]}}, half_sel};
            end
            f3_w: begin
                ext_rdata = {{(xlen-32){word_sel[31]}}, word_sel};
            end
            f3_bu: begin
                ext_rdata = {{(xlen-8){1'b0}}, byte_sel};
            end
            f3_hu: begin
                ext_rdata = {{(xlen-16){1'b0}}, half_sel};
            end
            f3_wu: begin
                ext_rdata = {{(xlen-32){1'b0}}, word_sel};
            end
            default: begin
                ext_rdata = rdata;  // ld, and the refused 111
            end
        endcase
    end

endmodule

`default_nettype wire

//--- access_align.sv
`timescale 1ns/10ps
`default_nettype none

module access_align import lsu_pkg::*; (
    input  wire logic [2:0]            funct3,
    input  wire logic                  write,
    input  wire logic [2:0]            offset,
    input  wire logic [xlen-1:0]       wdata,
    output logic      [strb_width-1:0] strb,
    output logic      [xlen-1:0]       lane_wdata,
    output logic                       bad
);

    logic [strb_width-1:0] size_mask;
    logic                  misaligned;
    logic                  bad_code;

    // funct3[1:0] is the access size for both directions
    always_comb begin
        case (funct3[1:0])
            2'b00: begin
                size_mask  = 8'h01;
                misaligned = 1'b0;
            end
            2'b01: begin
                size_mask  = 8'h03;
                misaligned = offset[0];
            end
            2'b10: begin
                size_mask  = 8'h0f;
                misaligned = |offset[1:0];
            end
            default: begin
                size_mask  = 8'hff;
                misaligned = |offset;
            end
        endcase
    end

    // stores have no unsigned variants, loads have no 111
    assign bad_code = write ? funct3[2] : (funct3 == 3'b111);
    assign bad      = misaligned | bad_code;

    assign lane_wdata = wdata << {offset, 3'b000};  // move to the addressed lane
    assign strb       = write ? (size_mask << offset) : '0;

endmodule

`default_nettype wire

//--- lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    localparam int xlen       = 64;
    localparam int strb_width = xlen / 8;

    // funct3 of the load and store opcodes
    localparam logic [2:0] f3_b  = 3'b000;
    localparam logic [2:0] f3_h  = 3'b001;
    localparam logic [2:0] f3_w  = 3'b010;
    localparam logic [2:0] f3_d  = 3'b011;
    localparam logic [2:0] f3_bu = 3'b100;
    localparam logic [2:0] f3_hu = 3'b101;
    localparam logic [2:0] f3_wu = 3'b110;

    // one doubleword seen as bytes, halfwords or words
    typedef union packed {
        logic [strb_width-1:0][7:0]  b;
        logic [xlen/16-1:0][15:0]    h;
        logic [xlen/32-1:0][31:0]    w;
    } lane_word_t;

endpackage

`default_nettype wire
